//--- design/csr_addr_pkg.sv
package csr_addr_pkg;

    localparam int CSR_ADDR_W = 14;
    localparam int CSR_DATA_W = 32;
    localparam int NUM_CSR    = 10; // kept registers, crmd through save3

    typedef enum logic [1:0] {
        CSR_OP_RD,
        CSR_OP_WR,
        CSR_OP_XCHG
    } csr_op_e;

    // storage slot of each kept register
    typedef enum logic [3:0] {
        IDX_CRMD,
        IDX_PRMD,
        IDX_ESTAT,
        IDX_ERA,
        IDX_BADV,
        IDX_EENTRY,
        IDX_SAVE0,
        IDX_SAVE1,
        IDX_SAVE2,
        IDX_SAVE3,
        IDX_NONE
    } csr_idx_e;

    // architectural csr numbers
    localparam logic [CSR_ADDR_W-1:0] ADDR_CRMD   = 14'd0;
    localparam logic [CSR_ADDR_W-1:0] ADDR_PRMD   = 14'd1;
    localparam logic [CSR_ADDR_W-1:0] ADDR_ESTAT  = 14'd5;
    localparam logic [CSR_ADDR_W-1:0] ADDR_ERA    = 14'd6;
    localparam logic [CSR_ADDR_W-1:0] ADDR_BADV   = 14'd7;
    localparam logic [CSR_ADDR_W-1:0] ADDR_EENTRY = 14'd12;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SAVE0  = 14'd48; // save1..3 follow

    localparam logic [CSR_DATA_W-1:0] CRMD_RESET = 32'h0000_0008; // da set

    // software-writable bits
    localparam logic [CSR_DATA_W-1:0] WMASK_CRMD   = 32'h0000_01FF;
    localparam logic [CSR_DATA_W-1:0] WMASK_PRMD   = 32'h0000_0007;
    localparam logic [CSR_DATA_W-1:0] WMASK_ESTAT  = 32'h0000_0003;
    localparam logic [CSR_DATA_W-1:0] WMASK_EENTRY = 32'hFFFF_FFC0;
    localparam logic [CSR_DATA_W-1:0] WMASK_ALL    = 32'hFFFF_FFFF;

endpackage

//--- design/csr_cmd_decode.sv
`timescale 1ns/1ps

module csr_cmd_decode (
    input  logic                                  cmd_valid_i,
    input  csr_addr_pkg::csr_op_e                 cmd_op_i,
    input  logic [csr_addr_pkg::CSR_ADDR_W-1:0]   cmd_addr_i,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0]   cmd_mask_i,
    input  logic                                  excp_valid_i,
    input  logic                                  ertn_i,
    input  logic                                  slot_free_i,
    output logic                                  cmd_ready_o,
    output logic                                  accept_o,
    output csr_addr_pkg::csr_idx_e                idx_o,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0]   wr_mask_o,
    output csr_excp_pkg::trap_e                   trap_o
);

    import csr_addr_pkg::*;
    import csr_excp_pkg::*;

    logic trap_pending;

    // exception wins over ertn
    always_comb begin
        if (excp_valid_i) begin
            trap_o = TRAP_EXCP;
        end else if (ertn_i) begin
            trap_o = TRAP_ERTN;
        end else begin
            trap_o = TRAP_NONE;
        end
    end

    assign trap_pending = excp_valid_i | ertn_i;
    assign cmd_ready_o  = ~trap_pending & slot_free_i; // traps stall the command port
    assign accept_o     = cmd_valid_i & cmd_ready_o;

    always_comb begin
        case (cmd_addr_i)
            ADDR_CRMD:                idx_o = IDX_CRMD;
            ADDR_PRMD:                idx_o = IDX_PRMD;
            ADDR_ESTAT:               idx_o = IDX_ESTAT;
            ADDR_ERA:                 idx_o = IDX_ERA;
            ADDR_BADV:                idx_o = IDX_BADV;
            ADDR_EENTRY:              idx_o = IDX_EENTRY;
            ADDR_SAVE0:               idx_o = IDX_SAVE0;
            ADDR_SAVE0 + 14'd1:       idx_o = IDX_SAVE1;
            ADDR_SAVE0 + 14'd2:       idx_o = IDX_SAVE2;
            ADDR_SAVE0 + 14'd3:       idx_o = IDX_SAVE3;
            default:                  idx_o = IDX_NONE; // reads zero, writes dropped
        endcase
    end

    always_comb begin
        case (cmd_op_i)
            CSR_OP_WR:   wr_mask_o = '1;
            CSR_OP_XCHG: wr_mask_o = cmd_mask_i;
            default:     wr_mask_o = '0; // csrrd
        endcase
    end

endmodule

//--- design/csr_excp_pkg.sv
package csr_excp_pkg;

    localparam int ECODE_W = 6;

    typedef enum logic [ECODE_W-1:0] {
        ECODE_ADEF = 6'h08, // fetch address error
        ECODE_ALE  = 6'h09, // misaligned access
        ECODE_SYS  = 6'h0B,
        ECODE_BRK  = 6'h0C
    } ecode_e;

    typedef enum logic [1:0] {
        TRAP_NONE,
        TRAP_EXCP,
        TRAP_ERTN
    } trap_e;

    // plv and ie in crmd, pplv and pie in prmd
    localparam int MODE_LSB = 0;
    localparam int MODE_MSB = 2;

    localparam int ESTAT_ECODE_LSB = 16;

endpackage

//--- design/csr_regfile.sv
`timescale 1ns/1ps

module csr_regfile (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  accept_i,
    input  csr_addr_pkg::csr_idx_e                idx_i,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0]   wr_mask_i,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0]   wdata_i,
    input  csr_excp_pkg::trap_e                   trap_i,
    input  csr_excp_pkg::ecode_e                  ecode_i,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0]   pc_i,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0]   badv_i,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0]   rdata_o,
    output logic                                  redirect_o,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0]   redirect_addr_o
);

    import csr_addr_pkg::*;
    import csr_excp_pkg::*;

    logic [CSR_DATA_W-1:0] csr_q [NUM_CSR];

    logic                  idx_hit;
    logic [CSR_DATA_W-1:0] wmask;
    logic [CSR_DATA_W-1:0] merge_mask;
    logic [CSR_DATA_W-1:0] old_val;
    logic                  addr_fault;

    logic                  redirect_q;
    logic [CSR_DATA_W-1:0] redirect_addr_q;

    assign idx_hit = int'(idx_i) < NUM_CSR;

    always_comb begin
        case (idx_i)
            IDX_CRMD:   wmask = WMASK_CRMD;
            IDX_PRMD:   wmask = WMASK_PRMD;
            IDX_ESTAT:  wmask = WMASK_ESTAT;
            IDX_EENTRY: wmask = WMASK_EENTRY;
            IDX_NONE:   wmask = '0;
            default:    wmask = WMASK_ALL; // era, badv, save0-3
        endcase
    end

    assign merge_mask = wmask & wr_mask_i;
    assign old_val    = idx_hit ? csr_q[idx_i] : '0;
    assign rdata_o    = old_val;

    // badv only captured for address faults
    assign addr_fault = (ecode_i == ECODE_ADEF) || (ecode_i == ECODE_ALE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CSR; i++) begin
                csr_q[i] <= '0;
            end
            csr_q[IDX_CRMD] <= CRMD_RESET;
        end else begin
            if (accept_i && idx_hit) begin
                csr_q[idx_i] <= (wdata_i & merge_mask) | (old_val & ~merge_mask);
            end
            case (trap_i)
                TRAP_EXCP: begin
                    csr_q[IDX_PRMD][MODE_MSB:MODE_LSB] <= csr_q[IDX_CRMD][MODE_MSB:MODE_LSB];
                    csr_q[IDX_CRMD][MODE_MSB:MODE_LSB] <= '0; // kernel, irq off
                    csr_q[IDX_ESTAT][ESTAT_ECODE_LSB +: ECODE_W] <= ecode_i;
                    csr_q[IDX_ERA] <= pc_i;
                    if (addr_fault) begin
                        csr_q[IDX_BADV] <= badv_i;
                    end
                end
                TRAP_ERTN: begin
                    csr_q[IDX_CRMD][MODE_MSB:MODE_LSB] <= csr_q[IDX_PRMD][MODE_MSB:MODE_LSB];
                end
                default: begin
                end
            endcase
        end
    end

    // one-cycle redirect after the trap edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            redirect_q <= 1'b0;
        end else begin
            redirect_q <= (trap_i != TRAP_NONE);
        end
    end

    always_ff @(posedge clk) begin
        if (trap_i == TRAP_EXCP) begin
            redirect_addr_q <= csr_q[IDX_EENTRY];
        end else if (trap_i == TRAP_ERTN) begin
            redirect_addr_q <= csr_q[IDX_ERA]; // back to faulting pc
        end
    end

    assign redirect_o      = redirect_q;
    assign redirect_addr_o = redirect_addr_q;

endmodule

//--- design/csr_resp_stage.sv
`timescale 1ns/1ps

module csr_resp_stage (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  accept_i,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0]   rdata_i,
    input  logic                                  resp_ready_i,
    output logic                                  slot_free_o,
    output logic                                  resp_valid_o,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0]   resp_rdata_o
);

    import csr_addr_pkg::*;

    logic                  valid_q;
    logic [CSR_DATA_W-1:0] data_q;

    // empty, or draining this cycle
    assign slot_free_o = ~valid_q | resp_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (accept_i) begin
            valid_q <= 1'b1;
        end else if (resp_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_i) begin
            data_q <= rdata_i; // old value, pre-write
        end
    end

    assign resp_valid_o = valid_q;
    assign resp_rdata_o = data_q;

endmodule

//--- design/csr_top.sv
`timescale 1ns/1ps

module csr_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    // command
    input  logic                                  cmd_valid_i,
    input  csr_addr_pkg::csr_op_e                 cmd_op_i,
    input  logic [csr_addr_pkg::CSR_ADDR_W-1:0]   cmd_addr_i,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0]   cmd_wdata_i,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0]   cmd_mask_i,
    output logic                                  cmd_ready_o,
    // response
    output logic                                  resp_valid_o,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0]   resp_rdata_o,
    input  logic                                  resp_ready_i,
    // trap events
    input  logic                                  excp_valid_i,
    input  csr_excp_pkg::ecode_e                  excp_ecode_i,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0]   excp_pc_i,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0]   excp_badv_i,
    input  logic                                  ertn_i,
    output logic                                  redirect_o,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0]   redirect_addr_o
);

    import csr_addr_pkg::*;
    import csr_excp_pkg::*;

    logic                  accept;
    logic                  slot_free;
    csr_idx_e              idx;
    logic [CSR_DATA_W-1:0] wr_mask;
    logic [CSR_DATA_W-1:0] old_data;
    trap_e                 trap;

    csr_cmd_decode i_decode (
        .cmd_valid_i  (cmd_valid_i),
        .cmd_op_i     (cmd_op_i),
        .cmd_addr_i   (cmd_addr_i),
        .cmd_mask_i   (cmd_mask_i),
        .excp_valid_i (excp_valid_i),
        .ertn_i       (ertn_i),
        .slot_free_i  (slot_free),
        .cmd_ready_o  (cmd_ready_o),
        .accept_o     (accept),
        .idx_o        (idx),
        .wr_mask_o    (wr_mask),
        .trap_o       (trap)
    );

    csr_regfile i_regfile (
        .clk             (clk),
        .rst_n           (rst_n),
        .accept_i        (accept),
        .idx_i           (idx),
        .wr_mask_i       (wr_mask),
        .wdata_i         (cmd_wdata_i),
        .trap_i          (trap),
        .ecode_i         (excp_ecode_i),
        .pc_i            (excp_pc_i),
        .badv_i          (excp_badv_i),
        .rdata_o         (old_data),
        .redirect_o      (redirect_o),
        .redirect_addr_o (redirect_addr_o)
    );

    csr_resp_stage i_resp (
        .clk          (clk),
        .rst_n        (rst_n),
        .accept_i     (accept),
        .rdata_i      (old_data),
        .resp_ready_i (resp_ready_i),
        .slot_free_o  (slot_free),
        .resp_valid_o (resp_valid_o),
        .resp_rdata_o (resp_rdata_o)
    );

endmodule

//--- files.f
design/csr_addr_pkg.sv
design/csr_excp_pkg.sv
design/csr_cmd_decode.sv
design/csr_regfile.sv
design/csr_resp_stage.sv
design/csr_top.sv
test/csr_asserts.sv
test/tb_csr.sv

//--- run.sh
#!/bin/sh
# build and run the csr testbench with verilator, run from the project root
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_csr -f files.f -o sim_csr \
    && ./obj_dir/sim_csr > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TESTS PASSED" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- test/csr_asserts.sv
`timescale 1ns/1ps

module csr_asserts (
    input logic                                clk,
    input logic                                rst_n,
    input logic                                cmd_ready_o,
    input logic                                resp_valid_o,
    input logic                                resp_ready_i,
    input logic [csr_addr_pkg::CSR_DATA_W-1:0] resp_rdata_o,
    input logic                                excp_valid_i,
    input logic                                ertn_i,
    input logic                                redirect_o
);

    // stalled response keeps valid and data
    resp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_rdata_o))
        else $error("response changed while stalled");

    trap_blocks_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        excp_valid_i || ertn_i |-> !cmd_ready_o)
        else $error("cmd_ready_o high during a trap");

    redirect_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_o |=> !redirect_o)
        else $error("redirect_o longer than one cycle");

    redirect_reset: assert property (@(posedge clk) !rst_n |=> !redirect_o)
        else $error("redirect_o high after reset");

endmodule

bind csr_top csr_asserts i_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_ready_o  (cmd_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_rdata_o (resp_rdata_o),
    .excp_valid_i (excp_valid_i),
    .ertn_i       (ertn_i),
    .redirect_o   (redirect_o)
);

//--- test/tb_csr.sv
`timescale 1ns/1ps

module tb_csr;

    import csr_addr_pkg::*;
    import csr_excp_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000; // whole run is about 200 cycles
    localparam logic [CSR_ADDR_W-1:0] ADDR_UNKNOWN = 14'h0123;

    // test order of the kept registers, same slots as csr_idx_e
    localparam logic [CSR_ADDR_W-1:0] ADDR_TAB [NUM_CSR] = '{ADDR_CRMD, ADDR_PRMD, ADDR_ESTAT,
        ADDR_ERA, ADDR_BADV, ADDR_EENTRY, ADDR_SAVE0, ADDR_SAVE0 + 14'd1, ADDR_SAVE0 + 14'd2,
        ADDR_SAVE0 + 14'd3};
    localparam logic [CSR_DATA_W-1:0] WMASK_TAB [NUM_CSR] = '{WMASK_CRMD, WMASK_PRMD,
        WMASK_ESTAT, WMASK_ALL, WMASK_ALL, WMASK_EENTRY, WMASK_ALL, WMASK_ALL, WMASK_ALL,
        WMASK_ALL};

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  cmd_valid;
    csr_op_e               cmd_op;
    logic [CSR_ADDR_W-1:0] cmd_addr;
    logic [CSR_DATA_W-1:0] cmd_wdata;
    logic [CSR_DATA_W-1:0] cmd_mask;
    logic                  cmd_ready;
    logic                  resp_valid;
    logic [CSR_DATA_W-1:0] resp_rdata;
    logic                  resp_ready;
    logic                  excp_valid;
    ecode_e                excp_ecode;
    logic [CSR_DATA_W-1:0] excp_pc;
    logic [CSR_DATA_W-1:0] excp_badv;
    logic                  ertn;
    logic                  redirect;
    logic [CSR_DATA_W-1:0] redirect_addr;

    logic [CSR_DATA_W-1:0] model [NUM_CSR]; // expected register contents
    integer                seed = 32'h9931_26ec;
    int                    mismatches = 0;
    int                    failures = 0;
    int                    cycles = 0;

    csr_top i_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd_valid_i     (cmd_valid),
        .cmd_op_i        (cmd_op),
        .cmd_addr_i      (cmd_addr),
        .cmd_wdata_i     (cmd_wdata),
        .cmd_mask_i      (cmd_mask),
        .cmd_ready_o     (cmd_ready),
        .resp_valid_o    (resp_valid),
        .resp_rdata_o    (resp_rdata),
        .resp_ready_i    (resp_ready),
        .excp_valid_i    (excp_valid),
        .excp_ecode_i    (excp_ecode),
        .excp_pc_i       (excp_pc),
        .excp_badv_i     (excp_badv),
        .ertn_i          (ertn),
        .redirect_o      (redirect),
        .redirect_addr_o (redirect_addr)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond) else begin
            $display("error: %s", what);
            failures++;
        end
    endtask

    // bits in both masks take the new data
    function automatic logic [31:0] merge_write(input logic [31:0] old, input logic [31:0] wmask,
                                                input logic [31:0] m, input logic [31:0] d);
        for (int b = 0; b < 32; b++) begin
            if (wmask[b] && m[b]) begin
                merge_write[b] = d[b];
            end else begin
                merge_write[b] = old[b];
            end
        end
    endfunction

    task automatic send_cmd(input csr_op_e op, input logic [CSR_ADDR_W-1:0] addr,
                            input logic [31:0] d, input logic [31:0] m,
                            output logic [31:0] rdata);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_addr  = addr;
        cmd_wdata = d;
        cmd_mask  = m;
        while (!cmd_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        cmd_valid = 1'b0;
        while (!resp_valid) begin
            @(negedge clk);
        end
        rdata = resp_rdata;
    endtask

    task automatic access_csr(input csr_op_e op, input csr_idx_e idx, input logic [31:0] d,
                              input logic [31:0] m, input string name);
        logic [31:0] rdata;
        logic [31:0] eff_mask;
        send_cmd(op, ADDR_TAB[idx], d, m, rdata);
        check_value(name, model[idx], rdata); // old value comes back
        if (op == CSR_OP_WR) begin
            eff_mask = '1;
        end else if (op == CSR_OP_XCHG) begin
            eff_mask = m;
        end else begin
            eff_mask = '0;
        end
        model[idx] = merge_write(model[idx], WMASK_TAB[idx], eff_mask, d);
    endtask

    task automatic read_all(input string name);
        logic [31:0] rdata;
        for (int i = 0; i < NUM_CSR; i++) begin
            send_cmd(CSR_OP_RD, ADDR_TAB[i], '0, '0, rdata);
            check_value($sformatf("%s[%0d]", name, i), model[i], rdata);
        end
    endtask

    task automatic raise_trap(input logic is_excp, input ecode_e code, input logic [31:0] pc,
                              input logic [31:0] addr, input logic [31:0] target,
                              input string name);
        @(negedge clk);
        excp_valid = is_excp;
        ertn       = ~is_excp;
        excp_ecode = code;
        excp_pc    = pc;
        excp_badv  = addr;
        @(negedge clk);
        excp_valid = 1'b0;
        ertn       = 1'b0;
        expect_true(redirect, "redirect_o did not rise after the trap");
        check_value(name, target, redirect_addr);
        @(negedge clk);
        expect_true(!redirect, "redirect_o stayed high for more than one cycle");
    endtask

    task automatic model_excp(input ecode_e code, input logic [31:0] pc, input logic [31:0] addr);
        model[IDX_PRMD][MODE_MSB:MODE_LSB] = model[IDX_CRMD][MODE_MSB:MODE_LSB];
        model[IDX_CRMD][MODE_MSB:MODE_LSB] = '0;
        model[IDX_ESTAT][ESTAT_ECODE_LSB +: ECODE_W] = code;
        model[IDX_ERA] = pc;
        if (code == ECODE_ADEF || code == ECODE_ALE) begin
            model[IDX_BADV] = addr;
        end
    endtask

    task automatic reset_test;
        logic [31:0] rdata;
        expect_true(cmd_ready, "cmd_ready_o low after reset");
        expect_true(!resp_valid && !redirect, "resp_valid_o or redirect_o high after reset");
        read_all("reset");
        send_cmd(CSR_OP_RD, ADDR_UNKNOWN, '0, '0, rdata);
        check_value("reset_unknown", '0, rdata);
    endtask

    task automatic csrwr_test;
        logic [31:0] rdata;
        access_csr(CSR_OP_WR, IDX_CRMD, 32'hFFFF_FFF0, '0, "csrwr_crmd");
        access_csr(CSR_OP_WR, IDX_ESTAT, 32'hFFFF_FFFF, '0, "csrwr_estat");
        access_csr(CSR_OP_WR, IDX_EENTRY, 32'h1C00_807F, '0, "csrwr_eentry");
        access_csr(CSR_OP_WR, IDX_SAVE2, 32'hA5A5_5A5A, '0, "csrwr_save2");
        read_all("csrwr_readback");
        send_cmd(CSR_OP_WR, ADDR_UNKNOWN, 32'hFFFF_FFFF, '0, rdata);
        check_value("csrwr_unknown", '0, rdata);
        read_all("csrwr_unknown_readback"); // nothing else moved
    endtask

    task automatic csrxchg_test;
        logic [31:0] d;
        logic [31:0] m;
        csr_idx_e    idx;
        for (int k = 0; k < 8; k++) begin
            d = $random(seed);
            m = $random(seed);
            if (k % 2 == 0) begin
                idx = IDX_SAVE0;
            end else begin
                idx = IDX_PRMD;
            end
            access_csr(CSR_OP_XCHG, idx, d, m, "csrxchg");
        end
        read_all("csrxchg_readback");
    endtask

    task automatic excp_test;
        access_csr(CSR_OP_WR, IDX_CRMD, 32'h0000_0005, '0, "excp_setup");
        access_csr(CSR_OP_WR, IDX_EENTRY, 32'h1C00_8000, '0, "excp_setup");
        raise_trap(1'b1, ECODE_ALE, 32'h1C00_1234, 32'h0000_BEE1, model[IDX_EENTRY], "excp_ale");
        model_excp(ECODE_ALE, 32'h1C00_1234, 32'h0000_BEE1);
        read_all("excp_ale_regs");
        // sys leaves badv alone
        raise_trap(1'b1, ECODE_SYS, 32'h1C00_2000, 32'hFFFF_0000, model[IDX_EENTRY], "excp_sys");
        model_excp(ECODE_SYS, 32'h1C00_2000, 32'hFFFF_0000);
        read_all("excp_sys_regs");
    endtask

    task automatic ertn_test;
        access_csr(CSR_OP_WR, IDX_PRMD, 32'h0000_0006, '0, "ertn_setup");
        raise_trap(1'b0, ECODE_SYS, '0, '0, model[IDX_ERA], "ertn_redirect");
        model[IDX_CRMD][MODE_MSB:MODE_LSB] = model[IDX_PRMD][MODE_MSB:MODE_LSB];
        read_all("ertn_regs");
    endtask

    task automatic backpressure_test;
        logic [31:0] exp_rd [3];
        @(negedge clk); // let the last response drain
        resp_ready = 1'b0;
        access_csr(CSR_OP_RD, IDX_SAVE2, '0, '0, "bp_stalled");
        repeat (3) begin
            @(negedge clk);
            expect_true(!cmd_ready, "cmd_ready_o high while the response stage is full");
            check_value("bp_hold", model[IDX_SAVE2], resp_rdata);
        end
        exp_rd[0] = model[IDX_SAVE1];
        exp_rd[1] = 32'h1357_9BDF;
        exp_rd[2] = 32'h2468_ACE0;
        resp_ready = 1'b1;
        for (int k = 0; k < 3; k++) begin
            cmd_valid = 1'b1;
            cmd_addr  = ADDR_SAVE0 + 14'd1;
            cmd_mask  = '0;
            cmd_wdata = exp_rd[(k == 0) ? 1 : 2];
            if (k == 2) begin
                cmd_op = CSR_OP_RD;
            end else begin
                cmd_op = CSR_OP_WR;
            end
            @(negedge clk);
            expect_true(resp_valid, "response missing in back-to-back commands");
            check_value("bp_burst", exp_rd[k], resp_rdata);
        end
        cmd_valid = 1'b0;
        model[IDX_SAVE1] = exp_rd[2];
    endtask

    initial begin
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd_op     = CSR_OP_RD;
        cmd_addr   = '0;
        cmd_wdata  = '0;
        cmd_mask   = '0;
        resp_ready = 1'b1;
        excp_valid = 1'b0;
        excp_ecode = ECODE_SYS;
        excp_pc    = '0;
        excp_badv  = '0;
        ertn       = 1'b0;
        for (int i = 0; i < NUM_CSR; i++) begin
            model[i] = '0;
        end
        model[IDX_CRMD] = CRMD_RESET;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        reset_test();
        csrwr_test();
        csrxchg_test();
        excp_test();
        ertn_test();
        backpressure_test();
        repeat (2) @(negedge clk);
        $display("%0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
